/* src/sensor_pkg.sv */
/*
 * sensor scan definitions
 * A2D channels, scan timing, scanner states and emitter pairs
 */
`default_nettype none

package sensor_pkg;

    localparam int a2d_width = 12;

    typedef logic [2:0] chan_t;

    localparam chan_t chan_first = 3'd1;   // scan order 1, 0, 4, 2, 3, 7
    localparam chan_t chan_last  = 3'd7;

    localparam int settle_cycles   = 4096; // emitter settling before a pair
    localparam int conv_gap_cycles = 32;

    // shared scan timer, sized for the longest wait
    typedef logic [$clog2(settle_cycles)-1:0] timer_t;

    localparam logic [7:0] pwm_on_count = 8'h8c;

    typedef enum logic [2:0] {
        idle,
        settle,
        conv_dummy,
        gap_dummy,
        conv_keep,
        wait_credit,
        gap_pair
    } scan_state_e;

    typedef enum logic [1:0] {
        pair_none,
        pair_inner,
        pair_middle,
        pair_outer
    } pair_e;

endpackage

`default_nettype wire

/* src/steer_pkg.sv */
/*
 * steering error definitions
 * error range, accumulator width and sample link sizing
 */
`default_nettype none

package steer_pkg;

    localparam int error_width = 12;
    localparam int error_max   = 2047;
    localparam int error_min   = -2048;
    localparam int accum_width = 16;   // holds the unsaturated six-term sum

    localparam int fifo_depth   = 4;
    localparam int credit_width = 3;   // counts 0 to fifo_depth

    localparam int led_width = 8;

endpackage

`default_nettype wire

/* src/ir_emitter_pwm.sv */
/*
 * IR emitter PWM
 * fixed duty cycle drive, steered to the emitter pair being measured
 */
`default_nettype none

module ir_emitter_pwm
    import sensor_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  enable,
    input  logic  restart,
    input  pair_e pair,
    output logic  ir_in_en,
    output logic  ir_mid_en,
    output logic  ir_out_en
);

    logic [7:0] pwm_cnt;
    logic       pwm_sig;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else if (enable && !restart) begin
            pwm_cnt <= pwm_cnt + 8'd1;
        end else begin
            pwm_cnt <= '0;   // new pair starts a fresh period
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_sig <= 1'b0;
        end else if (restart) begin
            pwm_sig <= 1'b1;
        end else if (!enable) begin
            pwm_sig <= 1'b0;
        end else if (pwm_cnt == 8'hff) begin
            pwm_sig <= 1'b1;
        end else if (pwm_cnt == pwm_on_count) begin
            pwm_sig <= 1'b0;
        end
    end

    assign ir_in_en  = enable && pwm_sig && (pair == pair_inner);
    assign ir_mid_en = enable && pwm_sig && (pair == pair_middle);
    assign ir_out_en = enable && pwm_sig && (pair == pair_outer);

endmodule

`default_nettype wire

/* src/sensor_scan.sv */
/*
 * sensor scanner
 * walks the six IR channels, runs a dummy and a kept A2D conversion
 * per channel and sends kept results out under credit flow control
 */
`default_nettype none

module sensor_scan
    import sensor_pkg::*;
    import steer_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 go,
    output logic                 strt_cnv,
    output chan_t                chnnl,
    input  logic                 cnv_cmplt,
    input  logic [a2d_width-1:0] a2d_res,
    output logic                 ir_in_en,
    output logic                 ir_mid_en,
    output logic                 ir_out_en,
    output logic                 push,
    output chan_t                push_chan,
    output logic [a2d_width-1:0] push_res,
    input  logic                 credit_ret
);

    scan_state_e             state;
    scan_state_e             state_nxt;
    timer_t                  timer;
    logic                    seen_low;
    logic                    cnv_done;
    logic                    keep_done;
    logic                    start;
    logic                    pwm_restart;
    logic                    emit_en;
    logic [credit_width-1:0] credits;
    pair_e                   pair;

    function automatic chan_t next_chan(input chan_t ch);
        case (ch)
            3'd1:    return 3'd0;
            3'd0:    return 3'd4;
            3'd4:    return 3'd2;
            3'd2:    return 3'd3;
            3'd3:    return 3'd7;
            default: return chan_first;
        endcase
    endfunction

    function automatic pair_e pair_of(input chan_t ch);
        case (ch)
            3'd1, 3'd0: return pair_inner;
            3'd4, 3'd2: return pair_middle;
            3'd3, 3'd7: return pair_outer;
            default:    return pair_none;
        endcase
    endfunction

    // second channel of its pair
    function automatic logic pair_last(input chan_t ch);
        return (ch == 3'd0) || (ch == 3'd2) || (ch == 3'd7);
    endfunction

    assign pair      = pair_of(chnnl);
    assign cnv_done  = seen_low && cnv_cmplt;
    assign keep_done = (state == conv_keep) && cnv_done;

    always_comb begin
        state_nxt   = state;
        start       = 1'b0;
        pwm_restart = 1'b0;
        case (state)
            idle: begin
                if (go) begin
                    state_nxt   = settle;
                    pwm_restart = 1'b1;
                end
            end
            settle: begin
                if (timer == timer_t'(settle_cycles - 1)) begin
                    state_nxt = conv_dummy;
                    start     = 1'b1;
                end
            end
            conv_dummy: begin
                if (cnv_done) begin
                    state_nxt = gap_dummy;   // result thrown away
                end
            end
            gap_dummy: begin
                if (timer == timer_t'(conv_gap_cycles - 1)) begin
                    if (credits == '0) begin
                        state_nxt = wait_credit;
                    end else begin
                        state_nxt = conv_keep;
                        start     = 1'b1;
                    end
                end
            end
            wait_credit: begin
                if (credits != '0) begin
                    state_nxt = conv_keep;
                    start     = 1'b1;
                end
            end
            conv_keep: begin
                if (cnv_done) begin
                    if (chnnl == chan_last) begin
                        state_nxt = idle;
                    end else if (pair_last(chnnl)) begin
                        state_nxt   = settle;
                        pwm_restart = 1'b1;
                    end else begin
                        state_nxt = gap_pair;
                    end
                end
            end
            gap_pair: begin
                if (timer == timer_t'(conv_gap_cycles - 1)) begin
                    state_nxt = conv_dummy;
                    start     = 1'b1;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            timer    <= '0;
            strt_cnv <= 1'b0;
            seen_low <= 1'b0;
        end else begin
            state    <= state_nxt;
            strt_cnv <= start;
            if (state_nxt != state) begin
                timer <= '0;
            end else if (state == settle || state == gap_dummy || state == gap_pair) begin
                timer <= timer + 1'b1;
            end
            // completion counts only after cnv_cmplt has dropped
            if (start) begin
                seen_low <= 1'b0;
            end else if (!cnv_cmplt && (state == conv_dummy || state == conv_keep)) begin
                seen_low <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chnnl   <= chan_first;
            emit_en <= 1'b0;
            push    <= 1'b0;
        end else begin
            push <= keep_done;
            if (keep_done) begin
                chnnl <= next_chan(chnnl);
            end
            if (pwm_restart) begin
                emit_en <= 1'b1;
            end else if (keep_done && pair_last(chnnl)) begin
                emit_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep_done) begin
            push_chan <= chnnl;
            push_res  <= a2d_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_width'(fifo_depth);
        end else begin
            case ({push, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    ir_emitter_pwm ir_emitter_pwm_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (emit_en),
        .restart   (pwm_restart),
        .pair      (pair),
        .ir_in_en  (ir_in_en),
        .ir_mid_en (ir_mid_en),
        .ir_out_en (ir_out_en)
    );

endmodule

`default_nettype wire

/* src/sample_fifo.sv */
/*
 * sample FIFO
 * four-entry buffer of kept samples, one credit returned per pop
 */
`default_nettype none

module sample_fifo (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  logic [2:0]  push_chan,
    input  logic [11:0] push_res,
    input  logic        pop,
    output logic        not_empty,
    output logic [2:0]  head_chan,
    output logic [11:0] head_res,
    output logic        credit_ret
);

    logic [2:0]  chan_mem [4];
    logic [11:0] res_mem  [4];
    logic [1:0]  wr_ptr;
    logic [1:0]  rd_ptr;
    logic [2:0]  count;    // 0 to 4
    logic        do_pop;

    assign not_empty = (count != 3'd0);
    assign do_pop    = pop && not_empty;

    always_ff @(posedge clk) begin
        if (push) begin
            chan_mem[wr_ptr] <= push_chan;
            res_mem[wr_ptr]  <= push_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

    assign head_chan  = chan_mem[rd_ptr];
    assign head_res   = res_mem[rd_ptr];
    assign credit_ret = do_pop;   // slot freed this cycle

endmodule

`default_nettype wire

/* src/error_accum.sv */
/*
 * error accumulator
 * weights and signs each kept sample by channel, sums a sweep and
 * presents the saturated steering error on a valid/ready output
 */
`default_nettype none

module error_accum
    import sensor_pkg::*;
    import steer_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          not_empty,
    input  chan_t                         head_chan,
    input  logic [a2d_width-1:0]          head_res,
    output logic                          pop,
    output logic signed [error_width-1:0] error,
    output logic                          error_vld,
    input  logic                          error_rdy,
    output logic [led_width-1:0]          leds
);

    logic                          lat_vld;
    chan_t                         lat_chan;
    logic [a2d_width-1:0]          lat_res;
    logic signed [accum_width-1:0] accum;
    logic signed [accum_width-1:0] term;
    logic signed [accum_width-1:0] sum_nxt;
    logic signed [error_width-1:0] sat_val;
    logic                          acc_last;

    // one sample in flight, none while an error waits
    assign pop = not_empty && !error_vld && !lat_vld;

    always_comb begin
        term = signed'({{(accum_width - a2d_width){1'b0}}, lat_res});
        case (lat_chan)
            3'd4, 3'd2: term = term <<< 1;
            3'd3, 3'd7: term = term <<< 2;
            default:    term = term;
        endcase
        if (lat_chan == 3'd0 || lat_chan == 3'd2 || lat_chan == 3'd7) begin
            term = -term;
        end
    end

    assign sum_nxt  = (lat_chan == chan_first) ? term : accum + term;
    assign acc_last = lat_vld && (lat_chan == chan_last);

    always_comb begin
        if (sum_nxt > accum_width'(error_max)) begin
            sat_val = error_width'(error_max);
        end else if (sum_nxt < accum_width'(error_min)) begin
            sat_val = error_width'(error_min);
        end else begin
            sat_val = sum_nxt[error_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            lat_chan <= head_chan;
            lat_res  <= head_res;
        end
        if (lat_vld) begin
            accum <= sum_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_vld   <= 1'b0;
            error     <= '0;
            leds      <= '0;
            error_vld <= 1'b0;
        end else begin
            lat_vld <= pop;
            if (acc_last) begin
                error     <= sat_val;
                leds      <= sat_val[error_width-1 -: led_width];
                error_vld <= 1'b1;
            end else if (error_rdy) begin
                error_vld <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/line_sensor_top.sv */
/*
 * line sensor top
 * scanner, sample FIFO and error accumulator
 */
`default_nettype none

module line_sensor_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               go,
    output logic               strt_cnv,
    output logic [2:0]         chnnl,
    input  logic               cnv_cmplt,
    input  logic [11:0]        a2d_res,
    output logic               ir_in_en,
    output logic               ir_mid_en,
    output logic               ir_out_en,
    output logic signed [11:0] error,
    output logic               error_vld,
    input  logic               error_rdy,
    output logic [7:0]         leds
);

    logic        push;
    logic [2:0]  push_chan;
    logic [11:0] push_res;
    logic        credit_ret;
    logic        pop;
    logic        not_empty;
    logic [2:0]  head_chan;
    logic [11:0] head_res;

    sensor_scan sensor_scan_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (go),
        .strt_cnv   (strt_cnv),
        .chnnl      (chnnl),
        .cnv_cmplt  (cnv_cmplt),
        .a2d_res    (a2d_res),
        .ir_in_en   (ir_in_en),
        .ir_mid_en  (ir_mid_en),
        .ir_out_en  (ir_out_en),
        .push       (push),
        .push_chan  (push_chan),
        .push_res   (push_res),
        .credit_ret (credit_ret)
    );

    sample_fifo sample_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_chan  (push_chan),
        .push_res   (push_res),
        .pop        (pop),
        .not_empty  (not_empty),
        .head_chan  (head_chan),
        .head_res   (head_res),
        .credit_ret (credit_ret)
    );

    error_accum error_accum_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .not_empty (not_empty),
        .head_chan (head_chan),
        .head_res  (head_res),
        .pop       (pop),
        .error     (error),
        .error_vld (error_vld),
        .error_rdy (error_rdy),
        .leds      (leds)
    );

endmodule

`default_nettype wire

/* test/line_sensor_asserts.sv */
/*
 * line sensor protocol assertions
 * A2D start pulses, emitter selection, output hold and FIFO credits
 */
`default_nettype none

module line_sensor_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               strt_cnv,
    input logic [2:0]         chnnl,
    input logic               ir_in_en,
    input logic               ir_mid_en,
    input logic               ir_out_en,
    input logic signed [11:0] error,
    input logic               error_vld,
    input logic               error_rdy,
    input logic               push,
    input logic               pop,
    input logic               credit_ret
);

    int fail_cnt = 0;   // failed assertions so far

    logic [3:0] in_flight;   // samples pushed and not yet popped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + 4'(push) - 4'(credit_ret);
        end
    end

    a_strt_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        strt_cnv |=> !strt_cnv)
        else begin
            $error("strt_cnv stayed high for two cycles");
            fail_cnt++;
        end

    a_ir_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ir_in_en, ir_mid_en, ir_out_en}))
        else begin
            $error("more than one IR emitter enabled");
            fail_cnt++;
        end

    a_ir_pair: assert property (@(posedge clk) disable iff (!rst_n)
        (!ir_in_en || chnnl == 3'd1 || chnnl == 3'd0) &&
        (!ir_mid_en || chnnl == 3'd4 || chnnl == 3'd2) &&
        (!ir_out_en || chnnl == 3'd3 || chnnl == 3'd7))
        else begin
            $error("IR emitter enabled for a pair other than the current channel's");
            fail_cnt++;
        end

    // output held while the consumer stalls
    a_error_hold: assert property (@(posedge clk) disable iff (!rst_n)
        error_vld && !error_rdy |=> error_vld && $stable(error))
        else begin
            $error("error changed or dropped before it was accepted");
            fail_cnt++;
        end

    a_no_pop: assert property (@(posedge clk) disable iff (!rst_n)
        error_vld |-> !pop)
        else begin
            $error("sample popped while an error was pending");
            fail_cnt++;
        end

    // scanner never sends past its credits
    a_credit: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight <= 4'd4)
        else begin
            $error("more samples in flight than the FIFO can hold");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* test/tb_line_sensor.sv */
/*
 * line sensor testbench
 * A2D model with random conversion times, per-sweep error checks,
 * back-pressure on the error output and an idle phase with go low
 */
`default_nettype none

module tb_line_sensor
    import sensor_pkg::*;
    import steer_pkg::*;
();

    localparam int clk_period    = 20;
    localparam int num_sweeps    = 5;
    localparam int sweep_cycles  = 3 * settle_cycles + 6 * (2 * conv_gap_cycles + 48);
    localparam int watchdog_time = (num_sweeps + 4) * sweep_cycles * clk_period;
    localparam logic [2:0] scan_order [6] = '{3'd1, 3'd0, 3'd4, 3'd2, 3'd3, 3'd7};

    logic               clk = 1'b0;
    logic               rst_n = 1'b0;
    logic               go = 1'b0;
    logic               cnv_cmplt = 1'b1;
    logic [11:0]        a2d_res = '0;
    logic               error_rdy = 1'b0;
    logic               strt_cnv;
    logic [2:0]         chnnl;
    logic               ir_in_en;
    logic               ir_mid_en;
    logic               ir_out_en;
    logic signed [11:0] error;
    logic               error_vld;
    logic [7:0]         leds;

    logic [11:0]        kept [8];   // kept result per channel, current sweep
    logic signed [11:0] exp_q [$];
    logic signed [11:0] exp_err;
    logic [2:0]         conv_chan;
    logic               hold_rdy = 1'b0;
    logic               vld_seen = 1'b0;
    int                 conv_idx = 0;
    int                 sweep_idx = 0;
    int                 strt_count = 0;
    int                 errors_seen = 0;
    int                 strt_mark;
    int                 strt_mid;

    line_sensor_top line_sensor_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (go),
        .strt_cnv  (strt_cnv),
        .chnnl     (chnnl),
        .cnv_cmplt (cnv_cmplt),
        .a2d_res   (a2d_res),
        .ir_in_en  (ir_in_en),
        .ir_mid_en (ir_mid_en),
        .ir_out_en (ir_out_en),
        .error     (error),
        .error_vld (error_vld),
        .error_rdy (error_rdy),
        .leds      (leds)
    );

    bind line_sensor_top line_sensor_asserts line_sensor_asserts_inst (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
            abort_run();
        end
    endtask

    task automatic wait_errors(input int n);
        int target;
        target = errors_seen + n;
        while (errors_seen < target) @(negedge clk);
    endtask

    // sweep modes: random, positive saturation, negative saturation, small
    function automatic logic [11:0] kept_value(input int mode, input logic [2:0] ch);
        logic plus;
        plus = (ch == 3'd1) || (ch == 3'd4) || (ch == 3'd3);
        case (mode)
            1:       return plus ? 12'hfff : 12'h000;
            2:       return plus ? 12'h000 : 12'hfff;
            3:       return 12'($urandom % 256);
            default: return 12'($urandom);
        endcase
    endfunction

    function automatic logic signed [11:0] saturated_error();
        int sum;
        sum = int'(kept[1]) - int'(kept[0]) + 2 * int'(kept[4]) - 2 * int'(kept[2])
            + 4 * int'(kept[3]) - 4 * int'(kept[7]);
        if (sum > error_max) begin
            sum = error_max;
        end else if (sum < error_min) begin
            sum = error_min;
        end
        return 12'(sum);
    endfunction

    // A2D model, even conversions are the dummies
    always begin
        @(negedge clk);
        if (rst_n && strt_cnv) begin
            strt_count++;
            conv_chan = chnnl;
            expect_equal("chnnl", 32'(chnnl), 32'(scan_order[conv_idx / 2]));
            cnv_cmplt = 1'b0;
            repeat (3 + $urandom % 18) @(negedge clk);
            expect_equal("chnnl", 32'(chnnl), 32'(conv_chan));
            if (conv_idx % 2 == 0) begin
                a2d_res = 12'($urandom);
            end else begin
                a2d_res = kept_value(sweep_idx % 4, conv_chan);
                kept[conv_chan] = a2d_res;
            end
            cnv_cmplt = 1'b1;
            if (conv_idx == 11) begin
                exp_q.push_back(saturated_error());
                sweep_idx++;
                conv_idx = 0;
            end else begin
                conv_idx++;
            end
        end
    end

    // output checks and error_rdy drive
    always @(negedge clk) begin
        if (rst_n) begin
            assert (line_sensor_top_inst.line_sensor_asserts_inst.fail_cnt == 0) else begin
                $display("a bound protocol assertion failed");
                abort_run();
            end
            if (error_vld && !vld_seen) begin
                if (exp_q.size() == 0) begin
                    $display("error_vld rose before any sweep completed");
                    abort_run();
                end else begin
                    exp_err = exp_q.pop_front();
                    expect_equal("error", 32'(error), 32'(exp_err));
                    expect_equal("leds", 32'(leds), 32'(exp_err[11:4]));
                    errors_seen++;
                end
            end
            vld_seen = error_vld;
            error_rdy = hold_rdy ? 1'b0 : ($urandom % 4 != 0);
        end
    end

    initial begin
        #(watchdog_time);
        $display("Timeout: the DUT did not finish the sweeps in time");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'hd5f2_f7c9));
        repeat (3) @(posedge clk);
        @(negedge clk);
        expect_equal("strt_cnv", 32'(strt_cnv), 32'd0);
        expect_equal("ir_en", 32'({ir_in_en, ir_mid_en, ir_out_en}), 32'd0);
        expect_equal("error_vld", 32'(error_vld), 32'd0);
        expect_equal("chnnl", 32'(chnnl), 32'd1);
        expect_equal("error", 32'(error), 32'd0);
        expect_equal("leds", 32'(leds), 32'd0);
        rst_n = 1'b1;
        go    = 1'b1;
        wait_errors(num_sweeps - 2);
        while (error_vld) @(negedge clk);
        hold_rdy = 1'b1;
        wait_errors(1);   // held, next sweep must stall on credits
        strt_mark = strt_count;
        repeat (sweep_cycles) @(negedge clk);
        strt_mid = strt_count;
        repeat (sweep_cycles) @(negedge clk);
        assert (strt_count == strt_mid && strt_count - strt_mark <= 12) else begin
            $display("strt_cnv kept pulsing while error_rdy was held low");
            abort_run();
        end
        go       = 1'b0;
        hold_rdy = 1'b0;
        wait_errors(1);
        strt_mark = strt_count;
        repeat (2 * settle_cycles) @(negedge clk);
        assert (strt_count == strt_mark) else begin
            $display("strt_cnv pulsed while idle with go low");
            abort_run();
        end
        if (line_sensor_top_inst.line_sensor_asserts_inst.fail_cnt == 0 && exp_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "errors left unchecked at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
src/sensor_pkg.sv
src/steer_pkg.sv
src/ir_emitter_pwm.sv
src/sensor_scan.sv
src/sample_fifo.sv
src/error_accum.sv
src/line_sensor_top.sv
test/line_sensor_asserts.sv
test/tb_line_sensor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the line sensor regression with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_line_sensor -f filelist.f \
    --Mdir obj_dir -o sim_line_sensor &&
./obj_dir/sim_line_sensor +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "Regression passed" &&
echo "simulation: PASS" ||
{ echo "simulation: FAIL"; exit 1; }
